//--- verilog/cpuFrontDefs.svh
`ifndef CPU_FRONT_DEFS_SVH
`define CPU_FRONT_DEFS_SVH

// bus and timing widths
`define CPU_DATA_W 8
`define CPU_TIME_W 3

// opcodes the loader looks at
`define CPU_OP_CLI 8'h58
`define CPU_OP_SEI 8'h78
// presented for reset, nmi and irq
`define CPU_OP_BRK 8'h00

// status register with the I flag set out of reset
`define CPU_PSR_RESET 8'h04
`define CPU_PSR_IBIT 2

// phase codes for the reset and interrupt sequence
`define CPU_INT_ADDR_CODE 3'd4
`define CPU_INT_OP_CODE 3'd2

`endif

//--- verilog/cpuFrontPkg.sv
`default_nettype none

`include "cpuFrontDefs.svh"

package cpuFrontPkg;

  // one byte off the external data bus
  typedef logic [`CPU_DATA_W-1:0] dataByte;

  // timing code, also used for the cycle number
  typedef logic [`CPU_TIME_W-1:0] timeCode;

  // where the current instruction came from
  // srcReset stays at zero so a cleared struct reads as reset
  typedef enum logic [1:0] {
    srcReset  = 2'd0,
    srcNmi    = 2'd1,
    srcIrq    = 2'd2,
    srcOpcode = 2'd3
  } instrSource;

  // loader output with the opcode in the upper bits
  typedef struct packed {
    dataByte    opcode;
    instrSource source;
    logic       valid;
  } loadedInstr;

endpackage

`default_nettype wire

//--- verilog/buttonConditioner.sv
`timescale 1ns/1ps
`default_nettype none

module buttonConditioner (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic button,
  output logic      level,
  output logic      pulse
);

  // first synchronizer stage
  logic syncFirst;
  // level from the previous clock, for the edge
  logic levelPrev;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      syncFirst <= 1'b0;
      level     <= 1'b0;
      levelPrev <= 1'b0;
      pulse     <= 1'b0;
    end else begin
      // two flops into the clock domain
      syncFirst <= button;
      level     <= syncFirst;
      levelPrev <= level;
      // registered rising edge, one clock after level
      pulse     <= level & ~levelPrev;
    end
  end

  // a held button gives a single pulse
  pulseSingle: assert property (
    @(posedge clk) disable iff (!rst) pulse |=> !pulse
  );

endmodule

`default_nettype wire

//--- verilog/instructionLoader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuFrontDefs.svh"

module instructionLoader (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   loadPulse,
  input  wire logic                   nmiPulse,
  input  wire logic                   irqLevel,
  input  wire cpuFrontPkg::dataByte   dataBus,
  output cpuFrontPkg::loadedInstr     instr,
  output cpuFrontPkg::dataByte        psr,
  output logic                        nmiRunning,
  output logic                        resetRunning,
  output logic                        irqRunning
);

  // what the next load would produce
  cpuFrontPkg::instrSource nextSource;
  cpuFrontPkg::dataByte    nextOpcode;
  cpuFrontPkg::dataByte    nextPsr;
  // reset sequence still owed
  logic resetPending;
  // nmi seen but not yet served
  logic nmiPending;

  // priority order is reset, nmi, unmasked irq and then the bus
  always_comb begin
    nextSource = cpuFrontPkg::srcOpcode;
    nextOpcode = dataBus;
    nextPsr    = psr;
    if (resetPending) begin
      nextSource                = cpuFrontPkg::srcReset;
      nextOpcode                = `CPU_OP_BRK;
      nextPsr[`CPU_PSR_IBIT]    = 1'b1;
    end else if (nmiPending) begin
      nextSource                = cpuFrontPkg::srcNmi;
      nextOpcode                = `CPU_OP_BRK;
      nextPsr[`CPU_PSR_IBIT]    = 1'b1;
    end else if (irqLevel && !psr[`CPU_PSR_IBIT]) begin
      nextSource                = cpuFrontPkg::srcIrq;
      nextOpcode                = `CPU_OP_BRK;
      nextPsr[`CPU_PSR_IBIT]    = 1'b1;
    end else if (dataBus == `CPU_OP_CLI) begin
      // cli lands together with the opcode
      nextPsr[`CPU_PSR_IBIT]    = 1'b0;
    end else if (dataBus == `CPU_OP_SEI) begin
      nextPsr[`CPU_PSR_IBIT]    = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      resetPending <= 1'b1;
      nmiPending   <= 1'b0;
      psr          <= `CPU_PSR_RESET;
      instr        <= '0;
      nmiRunning   <= 1'b0;
      resetRunning <= 1'b0;
      irqRunning   <= 1'b0;
    end else begin
      if (loadPulse) begin
        instr.opcode <= nextOpcode;
        instr.source <= nextSource;
        instr.valid  <= 1'b1;
        psr          <= nextPsr;
        // first load always serves the reset
        resetPending <= 1'b0;
        resetRunning <= (nextSource == cpuFrontPkg::srcReset);
        nmiRunning   <= (nextSource == cpuFrontPkg::srcNmi);
        irqRunning   <= (nextSource == cpuFrontPkg::srcIrq);
      end
      // a fresh nmi wins over clearing the served one
      if (nmiPulse) begin
        nmiPending <= 1'b1;
      end else if (loadPulse && nextSource == cpuFrontPkg::srcNmi) begin
        nmiPending <= 1'b0;
      end
    end
  end

  // masked irq must not be entered
  irqMasked: assert property (
    @(posedge clk) disable iff (!rst)
      (loadPulse && psr[`CPU_PSR_IBIT]) |=> !irqRunning
  );

endmodule

`default_nettype wire

//--- verilog/cycleDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuFrontDefs.svh"

module cycleDecoder (
  input  wire cpuFrontPkg::loadedInstr instr,
  output cpuFrontPkg::timeCode         addrCode,
  output cpuFrontPkg::timeCode         opCode
);

  always_comb begin
    // idle until something is loaded
    addrCode = 3'd1;
    opCode   = 3'd1;
    if (instr.valid) begin
      if (instr.source != cpuFrontPkg::srcOpcode) begin
        // reset and interrupts share one long sequence
        addrCode = `CPU_INT_ADDR_CODE;
        opCode   = `CPU_INT_OP_CODE;
      end else begin
        // addressing mode group sits in opcode bits 4:2
        case (instr.opcode[4:2])
          3'd0:    addrCode = 3'd1;
          3'd1:    addrCode = 3'd1;
          3'd2:    addrCode = 3'd0;
          3'd3:    addrCode = 3'd2;
          3'd4:    addrCode = 3'd3;
          3'd5:    addrCode = 3'd1;
          3'd6:    addrCode = 3'd2;
          default: addrCode = 3'd2;
        endcase
        opCode = 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/timingGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module timingGenerator (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire cpuFrontPkg::timeCode addrCode,
  input  wire cpuFrontPkg::timeCode opCode,
  output cpuFrontPkg::timeCode      cycle,
  output logic                      isAddressing
);

  // clocks left in the phase
  cpuFrontPkg::timeCode negTime;
  // code of the running phase, held until the boundary
  cpuFrontPkg::timeCode phaseCode;
  // code of the phase about to start
  cpuFrontPkg::timeCode enterCode;

  // addressing hands over to operation and back
  assign enterCode = isAddressing ? opCode : addrCode;

  // count up view of the down counter
  assign cycle = phaseCode - negTime;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // matches the idle decode of an empty loader
      negTime      <= 3'd1;
      phaseCode    <= 3'd1;
      isAddressing <= 1'b1;
    end else if (negTime == '0) begin
      // sample the next code at the boundary
      negTime      <= enterCode;
      phaseCode    <= enterCode;
      isAddressing <= ~isAddressing;
    end else begin
      negTime <= negTime - 3'd1;
    end
  end

  // count stays inside the latched phase
  cycleInPhase: assert property (
    @(posedge clk) disable iff (!rst) cycle <= phaseCode
  );

endmodule

`default_nettype wire

//--- verilog/hexDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module hexDisplay (
  input  wire cpuFrontPkg::dataByte opcode,
  input  wire cpuFrontPkg::timeCode cycle,
  output logic [6:0]                seg0,
  output logic [6:0]                seg1,
  output logic [6:0]                seg2
);

  // one nibble onto gfedcba with segments lit when high
  function automatic logic [6:0] hexSeg(input logic [3:0] nib);
    case (nib)
      4'h0:    hexSeg = 7'h3F;
      4'h1:    hexSeg = 7'h06;
      4'h2:    hexSeg = 7'h5B;
      4'h3:    hexSeg = 7'h4F;
      4'h4:    hexSeg = 7'h66;
      4'h5:    hexSeg = 7'h6D;
      4'h6:    hexSeg = 7'h7D;
      4'h7:    hexSeg = 7'h07;
      4'h8:    hexSeg = 7'h7F;
      4'h9:    hexSeg = 7'h6F;
      4'hA:    hexSeg = 7'h77;
      4'hB:    hexSeg = 7'h7C;
      4'hC:    hexSeg = 7'h39;
      4'hD:    hexSeg = 7'h5E;
      4'hE:    hexSeg = 7'h79;
      default: hexSeg = 7'h71;
    endcase
  endfunction

  // cycle count on the right digit
  assign seg0 = hexSeg(4'(cycle));
  assign seg1 = hexSeg(opcode[3:0]);
  assign seg2 = hexSeg(opcode[7:4]);

endmodule

`default_nettype wire

//--- verilog/cpuFrontTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuFrontTop (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // nmi, irq, load from bit 0 up
  input  wire logic [2:0]           pb,
  input  wire cpuFrontPkg::dataByte dataBus,
  output cpuFrontPkg::loadedInstr   instr,
  output cpuFrontPkg::dataByte      psr,
  output logic                      nmiRunning,
  output logic                      resetRunning,
  output logic                      irqRunning,
  output cpuFrontPkg::timeCode      cycle,
  output logic                      isAddressing,
  output logic [6:0]                seg0,
  output logic [6:0]                seg1,
  output logic [6:0]                seg2
);

  logic                 nmiPulse;
  logic                 irqLevel;
  logic                 loadPulse;
  cpuFrontPkg::timeCode addrCode;
  cpuFrontPkg::timeCode opCode;

  // nmi acts on the press
  buttonConditioner u_nmiButton (
    .clk    (clk),
    .rst    (rst),
    .button (pb[0]),
    .level  (),
    .pulse  (nmiPulse)
  );

  // irq is level sensitive
  buttonConditioner u_irqButton (
    .clk    (clk),
    .rst    (rst),
    .button (pb[1]),
    .level  (irqLevel),
    .pulse  ()
  );

  buttonConditioner u_loadButton (
    .clk    (clk),
    .rst    (rst),
    .button (pb[2]),
    .level  (),
    .pulse  (loadPulse)
  );

  instructionLoader u_loader (
    .clk          (clk),
    .rst          (rst),
    .loadPulse    (loadPulse),
    .nmiPulse     (nmiPulse),
    .irqLevel     (irqLevel),
    .dataBus      (dataBus),
    .instr        (instr),
    .psr          (psr),
    .nmiRunning   (nmiRunning),
    .resetRunning (resetRunning),
    .irqRunning   (irqRunning)
  );

  cycleDecoder u_decoder (
    .instr    (instr),
    .addrCode (addrCode),
    .opCode   (opCode)
  );

  timingGenerator u_timing (
    .clk          (clk),
    .rst          (rst),
    .addrCode     (addrCode),
    .opCode       (opCode),
    .cycle        (cycle),
    .isAddressing (isAddressing)
  );

  hexDisplay u_display (
    .opcode (instr.opcode),
    .cycle  (cycle),
    .seg0   (seg0),
    .seg1   (seg1),
    .seg2   (seg2)
  );

endmodule

`default_nettype wire

//--- tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk
);

  // 10 ns period starting low at time zero
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

//--- tb/cpuFrontTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuFrontDefs.svh"

module cpuFrontTb;

  // gfedcba patterns with hex F at the top down to 0
  localparam logic [111:0] segTable = {
    7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
    7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
  };
  // addressing code per opcode bits 4:2 with index 7 first
  localparam logic [23:0] addrTable = {3'd2, 3'd2, 3'd1, 3'd3, 3'd2, 3'd0, 3'd1, 3'd1};
  // longest phase pair is well under this
  localparam int phaseTimeout = 40;

  logic                    clk;
  logic                    rst;
  logic [2:0]              pb;
  cpuFrontPkg::dataByte    dataBus;
  cpuFrontPkg::loadedInstr instr;
  cpuFrontPkg::dataByte    psr;
  logic                    nmiRunning;
  logic                    resetRunning;
  logic                    irqRunning;
  cpuFrontPkg::timeCode    cycle;
  logic                    isAddressing;
  logic [6:0]              seg0;
  logic [6:0]              seg1;
  logic [6:0]              seg2;
  integer                  seed;
  integer                  rnd;

  // reference model state
  logic [3:0]              loadHist;
  logic [3:0]              nmiHist;
  logic [1:0]              irqHist;
  logic                    expResetPend;
  logic                    expNmiPend;
  cpuFrontPkg::dataByte    expPsr;
  cpuFrontPkg::loadedInstr expInstr;
  // irq, nmi, reset from the top bit down
  logic [2:0]              expRun;
  logic                    expIsAddr;
  cpuFrontPkg::timeCode    expCycle;
  cpuFrontPkg::timeCode    expCode;
  cpuFrontPkg::instrSource modelSrc;
  logic                    loadSeen;
  logic                    nmiSeen;

  clockGen u_clock (.clk(clk));

  cpuFrontTop u_dut (.*);

  function automatic logic [6:0] segOf(input logic [3:0] nib);
    int idx;
    idx = 7 * int'(nib);
    return segTable[idx +: 7];
  endfunction

  function automatic cpuFrontPkg::timeCode addrCodeOf(input cpuFrontPkg::loadedInstr li);
    int idx;
    idx = 3 * int'(li.opcode[4:2]);
    if (!li.valid) return 3'd1;
    if (li.source != cpuFrontPkg::srcOpcode) return `CPU_INT_ADDR_CODE;
    return addrTable[idx +: 3];
  endfunction

  function automatic cpuFrontPkg::timeCode opCodeOf(input cpuFrontPkg::loadedInstr li);
    if (li.valid && li.source != cpuFrontPkg::srcOpcode) return `CPU_INT_OP_CODE;
    return 3'd1;
  endfunction

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // button edge shows up 3 clocks after the press
  // irq level lags the button by 2
  assign loadSeen = loadHist[2] & ~loadHist[3];
  assign nmiSeen  = nmiHist[2] & ~nmiHist[3];

  always_comb begin
    if (expResetPend) modelSrc = cpuFrontPkg::srcReset;
    else if (expNmiPend) modelSrc = cpuFrontPkg::srcNmi;
    else if (irqHist[1] && !expPsr[`CPU_PSR_IBIT]) modelSrc = cpuFrontPkg::srcIrq;
    else modelSrc = cpuFrontPkg::srcOpcode;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      loadHist     <= '0;
      nmiHist      <= '0;
      irqHist      <= '0;
      expResetPend <= 1'b1;
      expNmiPend   <= 1'b0;
      expPsr       <= `CPU_PSR_RESET;
      expInstr     <= '0;
      expRun       <= '0;
      expIsAddr    <= 1'b1;
      expCycle     <= '0;
      // idle decode gives an addressing code of 1
      expCode      <= 3'd1;
    end else begin
      loadHist <= {loadHist[2:0], pb[2]};
      nmiHist  <= {nmiHist[2:0], pb[0]};
      irqHist  <= {irqHist[0], pb[1]};
      if (loadSeen) begin
        expResetPend    <= 1'b0;
        expInstr.valid  <= 1'b1;
        expInstr.source <= modelSrc;
        expInstr.opcode <= (modelSrc == cpuFrontPkg::srcOpcode) ? dataBus : `CPU_OP_BRK;
        expRun <= {modelSrc == cpuFrontPkg::srcIrq, modelSrc == cpuFrontPkg::srcNmi,
                   modelSrc == cpuFrontPkg::srcReset};
        // any entry masks
        // CLI and SEI count only when the bus is used
        if (modelSrc != cpuFrontPkg::srcOpcode) expPsr[`CPU_PSR_IBIT] <= 1'b1;
        else if (dataBus == `CPU_OP_CLI) expPsr[`CPU_PSR_IBIT] <= 1'b0;
        else if (dataBus == `CPU_OP_SEI) expPsr[`CPU_PSR_IBIT] <= 1'b1;
      end
      if (nmiSeen) expNmiPend <= 1'b1;
      else if (loadSeen && modelSrc == cpuFrontPkg::srcNmi) expNmiPend <= 1'b0;
      // phase ends once the count reaches its code
      if (expCycle == expCode) begin
        expIsAddr <= ~expIsAddr;
        expCycle  <= '0;
        expCode   <= expIsAddr ? opCodeOf(expInstr) : addrCodeOf(expInstr);
      end else begin
        expCycle <= expCycle + 3'd1;
      end
    end
  end

  loaderCheck: assert property (@(posedge clk) disable iff (!rst)
    instr == expInstr && psr == expPsr && {irqRunning, nmiRunning, resetRunning} == expRun)
    else stopOnError($sformatf("FAIL %0t: instr %h psr %h, expected instr %h psr %h",
      $time, $sampled(instr), $sampled(psr), $sampled(expInstr), $sampled(expPsr)));

  timingCheck: assert property (@(posedge clk) disable iff (!rst)
    isAddressing == expIsAddr && cycle == expCycle)
    else stopOnError($sformatf("FAIL %0t: phase %b cycle %0d, expected phase %b cycle %0d",
      $time, $sampled(isAddressing), $sampled(cycle), $sampled(expIsAddr), $sampled(expCycle)));

  displayCheck: assert property (@(posedge clk) disable iff (!rst)
    seg0 == segOf({1'b0, expCycle}) && seg1 == segOf(expInstr.opcode[3:0])
      && seg2 == segOf(expInstr.opcode[7:4]))
    else stopOnError($sformatf("FAIL %0t: segments %h %h %h, expected opcode %h cycle %0d",
      $time, $sampled(seg2), $sampled(seg1), $sampled(seg0), $sampled(expInstr.opcode),
      $sampled(expCycle)));

  // returns on the negedge right after an addressing phase begins
  task automatic waitPhaseStart();
    int   waited;
    logic wasAddr;
    logic started;
    waited  = 0;
    wasAddr = isAddressing;
    started = 1'b0;
    while (!started) begin
      if (waited == phaseTimeout) begin
        stopOnError("timed out waiting for an addressing phase to start");
      end else begin
        @(negedge clk);
        started = isAddressing && !wasAddr;
        wasAddr = isAddressing;
        waited++;
      end
    end
  endtask

  // press held for 4 clocks
  task automatic pressButton(input logic [1:0] which);
    pb[which] = 1'b1;
    repeat (4) @(negedge clk);
    pb[which] = 1'b0;
  endtask

  task automatic loadOpcode(input cpuFrontPkg::dataByte op);
    dataBus = op;
    pressButton(2'd2);
    // new code enters at the next addressing start and then runs a full pair
    waitPhaseStart();
    waitPhaseStart();
  endtask

  initial begin
    seed    = 32'hb9cf;
    rst     = 1'b0;
    pb      = 3'b000;
    dataBus = '0;
    repeat (2) @(negedge clk);
    rst = 1'b1;
    waitPhaseStart();
    // first load serves the reset
    loadOpcode(8'hEA);
    // irq held while masked so CLI comes from the bus
    pb[1] = 1'b1;
    loadOpcode(`CPU_OP_CLI);
    loadOpcode(8'hA9);
    pb[1] = 1'b0;
    loadOpcode(`CPU_OP_CLI);
    // nmi pending beats an unmasked irq
    pressButton(2'd0);
    pb[1] = 1'b1;
    loadOpcode(8'h6D);
    pb[1] = 1'b0;
    // SEI has to find the flag clear
    loadOpcode(`CPU_OP_CLI);
    loadOpcode(`CPU_OP_SEI);
    // irq stays masked after SEI
    pb[1] = 1'b1;
    loadOpcode(8'hEA);
    pb[1] = 1'b0;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      loadOpcode(rnd[7:0]);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/cpuFrontPkg.sv
verilog/buttonConditioner.sv
verilog/instructionLoader.sv
verilog/cycleDecoder.sv
verilog/timingGenerator.sv
verilog/hexDisplay.sv
verilog/cpuFrontTop.sv
tb/clockGen.sv
tb/cpuFrontTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# build the testbench with assertions enabled
verilator --binary --timing --assert -j 0 \
  --top-module cpuFrontTb \
  -f compile.f \
  -o cpuFrontSim

# exit status of the simulator decides pass or fail
./obj_dir/cpuFrontSim
